//--- rtl/fpMul_consts.svh
`ifndef FPMUL_CONSTS_SVH
`define FPMUL_CONSTS_SVH

// ========================================================================
// IEEE-754 single precision layout
// ========================================================================
`define FP_WIDTH   32
`define EXP_WIDTH  8
`define FRAC_WIDTH 23
`define EXP_BIAS   127

// Full significand product, 24 x 24 bits
`define PROD_WIDTH 48

// Returned for any NaN input and for inf times zero
`define QNAN_CANON 32'h7FC00000

`endif

//--- rtl/fpMulPkg.sv
`include "fpMul_consts.svh"

package fpMulPkg;

    // Codes outside this set fall back to nearest-even
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } roundMode_e;

    // Subnormals are folded into CLS_ZERO
    typedef enum logic [1:0] {
        CLS_ZERO = 2'd0,
        CLS_NORM = 2'd1,
        CLS_INF  = 2'd2,
        CLS_NAN  = 2'd3
    } opClass_e;

    // ========================================================================
    // Pipeline words
    // ========================================================================
    typedef struct packed {
        logic [`FP_WIDTH-1:0] opX;
        logic [`FP_WIDTH-1:0] opY;
        roundMode_e           rndMode;
    } mulReq_t;

    typedef struct packed {
        logic                         sign;
        logic signed [`EXP_WIDTH+1:0] expSum;
        logic [`FRAC_WIDTH:0]         sigX;
        logic [`FRAC_WIDTH:0]         sigY;
        opClass_e                     clsX;
        opClass_e                     clsY;
        roundMode_e                   rndMode;
    } unpacked_t;

    typedef struct packed {
        logic                         sign;
        logic signed [`EXP_WIDTH+1:0] expSum;
        logic [`PROD_WIDTH-1:0]       prod;
        opClass_e                     cls;
        roundMode_e                   rndMode;
    } product_t;

    typedef struct packed {
        logic [`FP_WIDTH-1:0] result;
        logic                 ovrf;
        logic                 udrf;
    } mulResp_t;

endpackage

//--- rtl/fpOperandUnpack.sv
`include "fpMul_consts.svh"

module fpOperandUnpack (
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    output logic                inReady,
    input  fpMulPkg::mulReq_t   inData,
    output logic                stValid,
    input  logic                stReady,
    output fpMulPkg::unpacked_t stData
);
    import fpMulPkg::*;

    localparam logic signed [`EXP_WIDTH+1:0] ExpBias = `EXP_BIAS;

    logic [`EXP_WIDTH-1:0]        expX;
    logic [`EXP_WIDTH-1:0]        expY;
    logic [`FRAC_WIDTH-1:0]       fracX;
    logic [`FRAC_WIDTH-1:0]       fracY;
    logic signed [`EXP_WIDTH+1:0] biasedX;
    logic signed [`EXP_WIDTH+1:0] biasedY;
    unpacked_t                    stNext;

    // Exponent all zeros covers zero and subnormal
    function automatic opClass_e classify(
        input logic [`EXP_WIDTH-1:0]  e,
        input logic [`FRAC_WIDTH-1:0] f
    );
        opClass_e cls;
        if (e == '0) begin
            cls = CLS_ZERO;
        end else if (e == '1) begin
            cls = (f == '0) ? CLS_INF : CLS_NAN;
        end else begin
            cls = CLS_NORM;
        end
        return cls;
    endfunction

    // ========================================================================
    // Field split and classification
    // ========================================================================
    always_comb begin
        expX  = inData.opX[`FP_WIDTH-2 -: `EXP_WIDTH];
        expY  = inData.opY[`FP_WIDTH-2 -: `EXP_WIDTH];
        fracX = inData.opX[`FRAC_WIDTH-1:0];
        fracY = inData.opY[`FRAC_WIDTH-1:0];

        biasedX = {2'b00, expX};
        biasedY = {2'b00, expY};

        stNext.sign    = inData.opX[`FP_WIDTH-1] ^ inData.opY[`FP_WIDTH-1];
        // Bias removed once so the sum stays biased
        stNext.expSum  = biasedX + biasedY - ExpBias;
        stNext.sigX    = {|expX, fracX};
        stNext.sigY    = {|expY, fracY};
        stNext.clsX    = classify(expX, fracX);
        stNext.clsY    = classify(expY, fracY);
        stNext.rndMode = inData.rndMode;
    end

    // Stage register
    assign inReady = ~stValid | stReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            stValid <= 1'b0;
        end else if (inReady) begin
            stValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            stData <= stNext;
        end
    end

endmodule

//--- rtl/boothRadix4Mult.sv
`include "fpMul_consts.svh"

module boothRadix4Mult (
    input  logic                clk,
    input  logic                rst,
    input  logic                stValid,
    output logic                stReady,
    input  fpMulPkg::unpacked_t stData,
    output logic                prValid,
    input  logic                prReady,
    output fpMulPkg::product_t  prData
);
    import fpMulPkg::*;

    localparam int SigWidth = `FRAC_WIDTH + 1;
    localparam int NumPp    = SigWidth / 2;

    logic [SigWidth:0]        mExt;
    logic [2:0]               boothCode [NumPp];
    logic [`PROD_WIDTH-1:0]   eM;
    logic [`PROD_WIDTH-1:0]   eMNeg;
    logic [`PROD_WIDTH-1:0]   eM2;
    logic [`PROD_WIDTH-1:0]   eM2Neg;
    logic [`PROD_WIDTH-1:0]   pp [NumPp];
    logic [`PROD_WIDTH-1:0]   topCorr;
    logic [`PROD_WIDTH-1:0]   prodSum;
    opClass_e                 clsMerged;
    product_t                 prNext;

    // Group to {neg, two, one}
    function automatic logic [2:0] boothEncode(input logic [2:0] grp);
        logic neg;
        logic two;
        logic one;
        neg = grp[2] & ~(grp[1] & grp[0]);
        two = (grp == 3'b011) | (grp == 3'b100);
        one = grp[1] ^ grp[0];
        return {neg, two, one};
    endfunction

    // ========================================================================
    // Booth recoding and partial product sum
    // ========================================================================
    always_comb begin
        // Implicit zero below the multiplier LSB
        mExt = {stData.sigY, 1'b0};

        // Multiplicand is positive so the extension is all zeros
        eM     = {{(`PROD_WIDTH-SigWidth){1'b0}}, stData.sigX};
        eMNeg  = -eM;
        eM2    = eM << 1;
        eM2Neg = -eM2;

        for (int i = 0; i < NumPp; i++) begin
            boothCode[i] = boothEncode(mExt[2*i +: 3]);
            case (boothCode[i])
                3'b001:  pp[i] = eM;
                3'b010:  pp[i] = eM2;
                3'b101:  pp[i] = eMNeg;
                3'b110:  pp[i] = eM2Neg;
                default: pp[i] = '0;
            endcase
        end

        // Top group sees the hidden bit as a sign
        // Unsigned result needs the multiplicand back at weight 2^24
        topCorr = stData.sigY[SigWidth-1] ? (eM << SigWidth) : '0;

        prodSum = topCorr;
        for (int i = 0; i < NumPp; i++) begin
            prodSum = prodSum + (pp[i] << (2 * i));
        end
    end

    // Special case class of the result
    always_comb begin
        if (stData.clsX == CLS_NAN || stData.clsY == CLS_NAN) begin
            clsMerged = CLS_NAN;
        end else if ((stData.clsX == CLS_INF && stData.clsY == CLS_ZERO) ||
                     (stData.clsX == CLS_ZERO && stData.clsY == CLS_INF)) begin
            clsMerged = CLS_NAN;
        end else if (stData.clsX == CLS_INF || stData.clsY == CLS_INF) begin
            clsMerged = CLS_INF;
        end else if (stData.clsX == CLS_ZERO || stData.clsY == CLS_ZERO) begin
            clsMerged = CLS_ZERO;
        end else begin
            clsMerged = CLS_NORM;
        end

        prNext.sign    = stData.sign;
        prNext.expSum  = stData.expSum;
        prNext.prod    = prodSum;
        prNext.cls     = clsMerged;
        prNext.rndMode = stData.rndMode;
    end

    assign stReady = ~prValid | prReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            prValid <= 1'b0;
        end else if (stReady) begin
            prValid <= stValid;
        end
    end

    always_ff @(posedge clk) begin
        if (stValid && stReady) begin
            prData <= prNext;
        end
    end

endmodule

//--- rtl/fpRoundPack.sv
`include "fpMul_consts.svh"

module fpRoundPack (
    input  logic               clk,
    input  logic               rst,
    input  logic               prValid,
    output logic               prReady,
    input  fpMulPkg::product_t prData,
    output logic               outValid,
    input  logic               outReady,
    output fpMulPkg::mulResp_t outData
);
    import fpMulPkg::*;

    localparam logic signed [`EXP_WIDTH+1:0] ExpOne = 1;
    localparam logic signed [`EXP_WIDTH+1:0] ExpInf = {2'b00, {`EXP_WIDTH{1'b1}}};

    logic                         normShift;
    logic [`FRAC_WIDTH:0]         sigPre;
    logic                         guardBit;
    logic                         stickyBit;
    logic signed [`EXP_WIDTH+1:0] expPre;
    logic signed [`EXP_WIDTH+1:0] expFinal;
    logic                         roundUp;
    logic                         ovfMaxFinite;
    logic [`FRAC_WIDTH+1:0]       sigRnd;
    logic [`FRAC_WIDTH-1:0]       fracFinal;
    mulResp_t                     respNext;

    // ========================================================================
    // Normalize and round
    // ========================================================================
    always_comb begin
        // Product lies in [1,4)
        normShift = prData.prod[`PROD_WIDTH-1];
        if (normShift) begin
            sigPre    = prData.prod[`PROD_WIDTH-1 -: `FRAC_WIDTH+1];
            guardBit  = prData.prod[`PROD_WIDTH-`FRAC_WIDTH-2];
            stickyBit = |prData.prod[`PROD_WIDTH-`FRAC_WIDTH-3:0];
            expPre    = prData.expSum + ExpOne;
        end else begin
            sigPre    = prData.prod[`PROD_WIDTH-2 -: `FRAC_WIDTH+1];
            guardBit  = prData.prod[`PROD_WIDTH-`FRAC_WIDTH-3];
            stickyBit = |prData.prod[`PROD_WIDTH-`FRAC_WIDTH-4:0];
            expPre    = prData.expSum;
        end

        // Increment decision and overflow saturation per mode
        case (prData.rndMode)
            RM_RTZ: begin
                roundUp      = 1'b0;
                ovfMaxFinite = 1'b1;
            end
            RM_RDN: begin
                roundUp      = prData.sign & (guardBit | stickyBit);
                ovfMaxFinite = ~prData.sign;
            end
            RM_RUP: begin
                roundUp      = ~prData.sign & (guardBit | stickyBit);
                ovfMaxFinite = prData.sign;
            end
            RM_RMM: begin
                roundUp      = guardBit;
                ovfMaxFinite = 1'b0;
            end
            default: begin
                roundUp      = guardBit & (stickyBit | sigPre[0]);
                ovfMaxFinite = 1'b0;
            end
        endcase

        sigRnd = {1'b0, sigPre} + {{(`FRAC_WIDTH+1){1'b0}}, roundUp};

        // Carry out leaves 1.000..0 one binade up
        if (sigRnd[`FRAC_WIDTH+1]) begin
            expFinal  = expPre + ExpOne;
            fracFinal = sigRnd[`FRAC_WIDTH:1];
        end else begin
            expFinal  = expPre;
            fracFinal = sigRnd[`FRAC_WIDTH-1:0];
        end
    end

    // ========================================================================
    // Specials, range checks and packing
    // ========================================================================
    always_comb begin
        respNext = '0;
        case (prData.cls)
            CLS_NAN:  respNext.result = `QNAN_CANON;
            CLS_INF:  respNext.result = {prData.sign, {`EXP_WIDTH{1'b1}}, {`FRAC_WIDTH{1'b0}}};
            CLS_ZERO: respNext.result = {prData.sign, {(`FP_WIDTH-1){1'b0}}};
            default: begin
                if (expFinal >= ExpInf) begin
                    respNext.ovrf = 1'b1;
                    if (ovfMaxFinite) begin
                        respNext.result = {prData.sign, {(`EXP_WIDTH-1){1'b1}}, 1'b0,
                                           {`FRAC_WIDTH{1'b1}}};
                    end else begin
                        respNext.result = {prData.sign, {`EXP_WIDTH{1'b1}},
                                           {`FRAC_WIDTH{1'b0}}};
                    end
                end else if (expFinal < ExpOne) begin
                    // No gradual underflow
                    respNext.udrf   = 1'b1;
                    respNext.result = {prData.sign, {(`FP_WIDTH-1){1'b0}}};
                end else begin
                    respNext.result = {prData.sign, expFinal[`EXP_WIDTH-1:0], fracFinal};
                end
            end
        endcase
    end

    assign prReady = ~outValid | outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (prReady) begin
            outValid <= prValid;
        end
    end

    always_ff @(posedge clk) begin
        if (prValid && prReady) begin
            outData <= respNext;
        end
    end

endmodule

//--- rtl/fpMulTop.sv
module fpMulTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    output logic               inReady,
    input  fpMulPkg::mulReq_t  inData,
    output logic               outValid,
    input  logic               outReady,
    output fpMulPkg::mulResp_t outData
);
    import fpMulPkg::*;

    // Stage 1 to stage 2
    logic      stValid;
    logic      stReady;
    unpacked_t stData;

    // Stage 2 to stage 3
    logic      prValid;
    logic      prReady;
    product_t  prData;

    fpOperandUnpack u_unpack (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .inReady (inReady),
        .inData  (inData),
        .stValid (stValid),
        .stReady (stReady),
        .stData  (stData)
    );

    boothRadix4Mult u_booth (
        .clk     (clk),
        .rst     (rst),
        .stValid (stValid),
        .stReady (stReady),
        .stData  (stData),
        .prValid (prValid),
        .prReady (prReady),
        .prData  (prData)
    );

    fpRoundPack u_round (
        .clk      (clk),
        .rst      (rst),
        .prValid  (prValid),
        .prReady  (prReady),
        .prData   (prData),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

endmodule

//--- dv/fpMul_sva.sv
`include "fpMul_consts.svh"

module fpMulChecker (
    input logic                clk,
    input logic                rst,
    input logic                stValid,
    input logic                stReady,
    input fpMulPkg::unpacked_t stData,
    input logic                prValid,
    input logic                prReady,
    input fpMulPkg::product_t  prData,
    input logic                outValid,
    input logic                outReady,
    input fpMulPkg::mulResp_t  outData
);
    timeunit 1ns;
    timeprecision 1ps;
    import fpMulPkg::*;

    localparam logic [`FRAC_WIDTH:0]   SigOne  = {1'b1, {`FRAC_WIDTH{1'b0}}};
    // 1.0 times 1.0 lands two bits below the top of the product
    localparam logic [`PROD_WIDTH-1:0] ProdOne = {2'b01, {(`PROD_WIDTH-2){1'b0}}};

    // Zero class only arises from zero or subnormal times a finite value
    zeroResult: assert property (@(posedge clk) disable iff (rst)
        (prValid && prReady && prData.cls == CLS_ZERO)
        |=> (outData.result == {$past(prData.sign), {(`FP_WIDTH-1){1'b0}}}))
        else $error("zero class did not give a signed zero result");

    boothUnit: assert property (@(posedge clk) disable iff (rst)
        (stValid && stReady && stData.sigX == SigOne && stData.sigY == SigOne)
        |=> (prData.prod == ProdOne))
        else $error("Booth product of two unit significands is wrong");

    holdOut: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outData)))
        else $error("output word changed while stalled");

    resetIdle: assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid high during reset");

endmodule

bind fpMulTop fpMulChecker u_checker (
    .clk      (clk),
    .rst      (rst),
    .stValid  (stValid),
    .stReady  (stReady),
    .stData   (stData),
    .prValid  (prValid),
    .prReady  (prReady),
    .prData   (prData),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
);

//--- dv/tb_fpMul.sv
`include "fpMul_consts.svh"

module tb_fpMul;
    timeunit 1ns;
    timeprecision 1ps;
    import fpMulPkg::*;

    localparam int Cols        = 6;
    localparam int MaxVec      = 64;
    localparam int Timeout     = 200;
    localparam int QuietCycles = 20;

    logic     clk;
    logic     rst;
    logic     inValid;
    logic     inReady;
    mulReq_t  inData;
    logic     outValid;
    logic     outReady;
    mulResp_t outData;

    // Six words per vector, see the golden file header
    logic [31:0] gold [0:Cols*MaxVec-1];
    int          numVec;
    int          errCount;
    int          checkCount;
    int          rxCount;
    bit          timedOut;
    bit          holdReady;
    logic [31:0] rngDrv;
    logic [31:0] rngBp;

    fpMulTop u_fpMulTop (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Random back-pressure, released for the final drain
    initial begin
        forever begin
            @(posedge clk);
            #2;
            rngBp    = xorshift32(rngBp);
            outReady = holdReady | (rngBp[1:0] != 2'b00);
        end
    end

    // ========================================================================
    // Driver and monitor
    // ========================================================================
    task automatic driveVectors();
        int waitCnt;
        bit accepted;
        for (int i = 0; i < numVec && !timedOut; i++) begin
            rngDrv = xorshift32(rngDrv);
            // Occasional idle gap of one to four cycles
            if (rngDrv[2:0] == 3'd0) begin
                repeat (rngDrv[4:3] + 1) begin
                    @(posedge clk);
                    #2;
                end
            end
            inValid        = 1'b1;
            inData.opX     = gold[Cols*i];
            inData.opY     = gold[Cols*i+1];
            inData.rndMode = roundMode_e'(gold[Cols*i+2][2:0]);
            waitCnt        = 0;
            accepted       = 1'b0;
            while (!accepted && !timedOut) begin
                @(negedge clk);
                accepted = inReady;
                @(posedge clk);
                #2;
                waitCnt++;
                if (!accepted && waitCnt >= Timeout) begin
                    $display("Timeout: vector %0d was never accepted", i);
                    timedOut = 1'b1;
                end
            end
            inValid = 1'b0;
        end
    endtask

    task automatic collectResponses();
        int waitCnt;
        bit got;
        for (int i = 0; i < numVec && !timedOut; i++) begin
            waitCnt = 0;
            got     = 1'b0;
            while (!got && !timedOut) begin
                @(negedge clk);
                if (outValid && outReady) begin
                    got = 1'b1;
                    rxCount++;
                    checkValue("outData.result", outData.result, gold[Cols*i+3]);
                    checkValue("outData.ovrf", 32'(outData.ovrf), gold[Cols*i+4]);
                    checkValue("outData.udrf", 32'(outData.udrf), gold[Cols*i+5]);
                end else begin
                    waitCnt++;
                    if (waitCnt >= Timeout) begin
                        $display("Timeout: no response for vector %0d", i);
                        timedOut = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic checkQuiet();
        holdReady = 1'b1;
        for (int c = 0; c < QuietCycles; c++) begin
            @(negedge clk);
            if (outValid) begin
                errCount++;
                $display("Extra response after the last vector at %0d ns", $time);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        inValid    = 1'b0;
        inData     = '0;
        outReady   = 1'b0;
        holdReady  = 1'b0;
        timedOut   = 1'b0;
        errCount   = 0;
        checkCount = 0;
        rxCount    = 0;
        rngDrv     = 32'hb7fd94c2;
        rngBp      = ~rngDrv;

        // Mode column above 7 marks the end of the data
        for (int k = 0; k < Cols*MaxVec; k++) begin
            gold[k] = 32'hF000_0000 | k;
        end
        $readmemh("dv/fpMul_golden.txt", gold);
        numVec = 0;
        while (numVec < MaxVec && gold[Cols*numVec+2] < 32'd8) begin
            numVec++;
        end

        repeat (5) @(posedge clk);
        #2;
        // Empty pipeline after reset
        checkValue("inReady", 32'(inReady), 32'd1);
        checkValue("outValid", 32'(outValid), 32'd0);
        rst = 1'b0;
        if (numVec == 0) begin
            errCount++;
            $display("No vectors could be read from the golden file");
        end

        fork
            driveVectors();
            collectResponses();
        join
        if (!timedOut) begin
            checkQuiet();
        end

        $display("Responses %0d of %0d, checks %0d, errors %0d, timeouts %0d",
                 rxCount, numVec, checkCount, errCount, timedOut);
        if (errCount == 0 && !timedOut && rxCount == numVec && numVec > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- fpMul.f
+incdir+rtl
rtl/fpMulPkg.sv
rtl/fpOperandUnpack.sv
rtl/boothRadix4Mult.sv
rtl/fpRoundPack.sv
rtl/fpMulTop.sv
dv/fpMul_sva.sv
dv/tb_fpMul.sv

//--- Makefile
TOP := tb_fpMul

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f fpMul.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/fpMul_golden.txt
// opX opY mode result ovrf udrf, one product per line, all hex
// mode 0 RNE, 1 RTZ, 2 RDN, 3 RUP, 4 RMM
3F800000 3F800000 0 3F800000 0 0
C0200000 40800000 0 C1200000 0 0
40400000 40400000 0 41100000 0 0
3F800001 3FC00000 0 3FC00002 0 0
3F800003 3FC00000 0 3FC00004 0 0
3FFFFFFE 3F800001 0 40000000 0 0
3F800001 3FC00001 1 3FC00002 0 0
3F800001 3FC00001 2 3FC00002 0 0
3F800001 3FC00001 3 3FC00003 0 0
3F800001 3FC00001 4 3FC00003 0 0
BF800001 3FC00001 2 BFC00003 0 0
BF800001 3FC00001 3 BFC00002 0 0
3F800003 3FC00000 4 3FC00005 0 0
80000000 40400000 0 80000000 0 0
00400000 C0000000 0 80000000 0 0
7F800000 C0000000 0 FF800000 0 0
7F800000 00000000 0 7FC00000 0 0
7F800001 3F800000 0 7FC00000 0 0
7F000000 40000000 0 7F800000 1 0
7F000000 40000000 1 7F7FFFFF 1 0
FF000000 40000000 3 FF7FFFFF 1 0
80800000 3F000000 0 80000000 0 1
